// File: common/mipsPkg.sv
package mipsPkg;

	// primary opcodes
	localparam logic [5:0] opSpecial = 6'h00;
	localparam logic [5:0] opJ       = 6'h02;
	localparam logic [5:0] opBeq     = 6'h04;
	localparam logic [5:0] opBne     = 6'h05;
	localparam logic [5:0] opAddiu   = 6'h09;
	localparam logic [5:0] opOri     = 6'h0d;
	localparam logic [5:0] opLui     = 6'h0f;
	localparam logic [5:0] opLw      = 6'h23;
	localparam logic [5:0] opSw      = 6'h2b;

	// funct field of the special opcode
	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSubu = 6'h23;
	localparam logic [5:0] fnAnd  = 6'h24;
	localparam logic [5:0] fnOr   = 6'h25;
	localparam logic [5:0] fnSlt  = 6'h2a;

	// execute operand sources
	localparam logic [1:0] fwdNone = 2'b00;
	localparam logic [1:0] fwdWb   = 2'b01;
	localparam logic [1:0] fwdMem  = 2'b10;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt,
		aluLui
	} aluOp;

	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic memWrite;
		logic aluSrcImm;
		logic regDstRd;
		logic zeroExtImm;
		logic branchEq;
		logic branchNe;
		logic jump;
		aluOp aluControl;
	} ctrlBundle;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] rsVal;
		logic [31:0] rtVal;
		logic [31:0] imm;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  dest;
		ctrlBundle   ctrl;
	} idExBundle;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] aluResult;
		logic [31:0] storeData;
		logic [4:0]  dest;
		logic        regWrite;
		logic        memToReg;
		logic        memWrite;
	} exMemBundle;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] result;
		logic [4:0]  dest;
		logic        regWrite;
	} memWbBundle;

	typedef struct packed {
		logic        memWrite;
		logic [3:0]  byteEnable;
		logic [31:0] addr;
		logic [31:0] writeData;
	} dataReq;

	typedef struct packed {
		logic [31:0] pc;
		logic        wen;
		logic [4:0]  wnum;
		logic [31:0] wdata;
	} debugWb;

endpackage

// File: datapath/datapath.sv
`timescale 1ns/1ps

module datapath #(
	parameter logic [31:0] resetPc = 32'hBFC00000
) (
	input  logic               clk,
	input  logic               arstN,
	output logic [31:0]        pcF,
	input  logic [31:0]        instrF,
	output mipsPkg::dataReq    dataOut,
	input  logic [31:0]        readData,
	output mipsPkg::debugWb    debugOut,
	output logic [31:0]        instrD,
	input  mipsPkg::ctrlBundle ctrlD,
	output logic [4:0]         rsD,
	output logic [4:0]         rtD,
	output logic               branchD,
	output logic [4:0]         rsE,
	output logic [4:0]         rtE,
	output logic [4:0]         destE,
	output logic               regWriteE,
	output logic               memToRegE,
	output logic [4:0]         destM,
	output logic               regWriteM,
	output logic               memToRegM,
	output logic [4:0]         destW,
	output logic               regWriteW,
	output logic               redirectD,
	input  logic               stallF,
	input  logic               stallD,
	input  logic               flushD,
	input  logic               flushE,
	input  logic               forwardAD,
	input  logic               forwardBD,
	input  logic [1:0]         forwardAE,
	input  logic [1:0]         forwardBE,
	output logic [4:0]         rfRaddrA,
	output logic [4:0]         rfRaddrB,
	input  logic [31:0]        rfRdataA,
	input  logic [31:0]        rfRdataB,
	output logic               rfWen,
	output logic [4:0]         rfWaddr,
	output logic [31:0]        rfWdata
);

	logic [31:0] pcNext;
	logic [31:0] pcD;
	logic [31:0] pcPlus4D;
	logic [31:0] immD;
	logic [31:0] branchTargetD;
	logic [31:0] jumpTargetD;
	logic [31:0] srcAD;
	logic [31:0] srcBD;
	logic        takenD;
	logic [31:0] srcAE;
	logic [31:0] srcBE;
	logic [31:0] aluResultE;
	logic [31:0] resultM;
	mipsPkg::idExBundle  idExNext;
	mipsPkg::idExBundle  idEx;
	mipsPkg::exMemBundle exMemNext;
	mipsPkg::exMemBundle exMem;
	mipsPkg::memWbBundle memWbNext;
	mipsPkg::memWbBundle memWb;

	// redirect comes straight from decode
	assign pcNext = ctrlD.jump ? jumpTargetD : takenD ? branchTargetD : pcF + 32'd4;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pcF <= resetPc;
		end else if (!stallF) begin
			pcF <= pcNext;
		end
	end

	pipeStage #(.payloadType(logic [31:0])) u_instrD (
		.clk(clk), .arstN(arstN), .enable(!stallD), .flush(flushD), .d(instrF), .q(instrD)
	);
	pipeStage #(.payloadType(logic [31:0])) u_pcD (
		.clk(clk), .arstN(arstN), .enable(!stallD), .flush(flushD), .d(pcF), .q(pcD)
	);

	// decode
	assign rsD      = instrD[25:21];
	assign rtD      = instrD[20:16];
	assign rfRaddrA = rsD;
	assign rfRaddrB = rtD;
	assign pcPlus4D = pcD + 32'd4;
	assign immD     = ctrlD.zeroExtImm ? {16'd0, instrD[15:0]} :
		{{16{instrD[15]}}, instrD[15:0]};
	assign branchTargetD = pcPlus4D + {immD[29:0], 2'b00};
	assign jumpTargetD   = {pcPlus4D[31:28], instrD[25:0], 2'b00};

	assign srcAD     = forwardAD ? exMem.aluResult : rfRdataA;
	assign srcBD     = forwardBD ? exMem.aluResult : rfRdataB;
	assign branchD   = ctrlD.branchEq || ctrlD.branchNe;
	assign takenD    = (ctrlD.branchEq && srcAD == srcBD) || (ctrlD.branchNe && srcAD != srcBD);
	assign redirectD = takenD || ctrlD.jump;

	always_comb begin
		idExNext.pc    = pcD;
		idExNext.rsVal = rfRdataA;
		idExNext.rtVal = rfRdataB;
		idExNext.imm   = immD;
		idExNext.rs    = rsD;
		idExNext.rt    = rtD;
		idExNext.dest  = ctrlD.regDstRd ? instrD[15:11] : rtD;
		idExNext.ctrl  = ctrlD;
	end

	pipeStage #(.payloadType(mipsPkg::idExBundle)) u_idEx (
		.clk(clk), .arstN(arstN), .enable(1'b1), .flush(flushE), .d(idExNext), .q(idEx)
	);

	// execute
	assign rsE       = idEx.rs;
	assign rtE       = idEx.rt;
	assign destE     = idEx.dest;
	assign regWriteE = idEx.ctrl.regWrite;
	assign memToRegE = idEx.ctrl.memToReg;

	assign srcAE = (forwardAE == mipsPkg::fwdMem) ? exMem.aluResult :
		(forwardAE == mipsPkg::fwdWb) ? memWb.result : idEx.rsVal;
	assign srcBE = (forwardBE == mipsPkg::fwdMem) ? exMem.aluResult :
		(forwardBE == mipsPkg::fwdWb) ? memWb.result : idEx.rtVal;

	aluUnit u_alu (
		.opA(srcAE),
		.opB(idEx.ctrl.aluSrcImm ? idEx.imm : srcBE),
		.op(idEx.ctrl.aluControl),
		.result(aluResultE)
	);

	always_comb begin
		exMemNext.pc        = idEx.pc;
		exMemNext.aluResult = aluResultE;
		// store data is the forwarded rt value
		exMemNext.storeData = srcBE;
		exMemNext.dest      = idEx.dest;
		exMemNext.regWrite  = idEx.ctrl.regWrite;
		exMemNext.memToReg  = idEx.ctrl.memToReg;
		exMemNext.memWrite  = idEx.ctrl.memWrite;
	end

	pipeStage #(.payloadType(mipsPkg::exMemBundle)) u_exMem (
		.clk(clk), .arstN(arstN), .enable(1'b1), .flush(1'b0), .d(exMemNext), .q(exMem)
	);

	// memory stage does word accesses only
	assign destM     = exMem.dest;
	assign regWriteM = exMem.regWrite;
	assign memToRegM = exMem.memToReg;

	assign dataOut.memWrite   = exMem.memWrite;
	assign dataOut.byteEnable = {4{exMem.memWrite}};
	assign dataOut.addr       = exMem.aluResult;
	assign dataOut.writeData  = exMem.storeData;

	assign resultM = exMem.memToReg ? readData : exMem.aluResult;

	always_comb begin
		memWbNext.pc       = exMem.pc;
		memWbNext.result   = resultM;
		memWbNext.dest     = exMem.dest;
		memWbNext.regWrite = exMem.regWrite;
	end

	pipeStage #(.payloadType(mipsPkg::memWbBundle)) u_memWb (
		.clk(clk), .arstN(arstN), .enable(1'b1), .flush(1'b0), .d(memWbNext), .q(memWb)
	);

	// r0 targets retire silently in writeback
	assign destW     = memWb.dest;
	assign regWriteW = memWb.regWrite;
	assign rfWen     = memWb.regWrite && memWb.dest != 5'd0;
	assign rfWaddr   = memWb.dest;
	assign rfWdata   = memWb.result;

	assign debugOut.pc    = memWb.pc;
	assign debugOut.wen   = rfWen;
	assign debugOut.wnum  = memWb.dest;
	assign debugOut.wdata = memWb.result;

endmodule

// File: logic/aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
	input  logic [31:0]   opA,
	input  logic [31:0]   opB,
	input  mipsPkg::aluOp op,
	output logic [31:0]   result
);

	logic lessThan;

	// signed compare for slt
	assign lessThan = $signed(opA) < $signed(opB);

	always_comb begin
		case (op)
			mipsPkg::aluAdd: begin
				result = opA + opB;
			end
			mipsPkg::aluSub: begin
				result = opA - opB;
			end
			mipsPkg::aluAnd: begin
				result = opA & opB;
			end
			mipsPkg::aluOr: begin
				result = opA | opB;
			end
			mipsPkg::aluSlt: begin
				result = {31'd0, lessThan};
			end
			// immediate lands in the upper half
			mipsPkg::aluLui: begin
				result = {opB[15:0], 16'd0};
			end
			default: begin
				result = 32'd0;
			end
		endcase
	end

endmodule

// File: logic/controlDecoder.sv
`timescale 1ns/1ps

module controlDecoder (
	input  logic [31:0]        instr,
	output mipsPkg::ctrlBundle ctrl
);

	logic [5:0] opcode;
	logic [5:0] funct;

	assign opcode = instr[31:26];
	assign funct  = instr[5:0];

	always_comb begin
		ctrl = '0;
		case (opcode)
			mipsPkg::opSpecial: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDstRd = 1'b1;
				case (funct)
					mipsPkg::fnAddu: ctrl.aluControl = mipsPkg::aluAdd;
					mipsPkg::fnSubu: ctrl.aluControl = mipsPkg::aluSub;
					mipsPkg::fnAnd:  ctrl.aluControl = mipsPkg::aluAnd;
					mipsPkg::fnOr:   ctrl.aluControl = mipsPkg::aluOr;
					mipsPkg::fnSlt:  ctrl.aluControl = mipsPkg::aluSlt;
					// sll r0 and anything else unsupported becomes a nop
					default:         ctrl = '0;
				endcase
			end
			mipsPkg::opAddiu: begin
				ctrl.regWrite   = 1'b1;
				ctrl.aluSrcImm  = 1'b1;
				ctrl.aluControl = mipsPkg::aluAdd;
			end
			mipsPkg::opOri: begin
				ctrl.regWrite   = 1'b1;
				ctrl.aluSrcImm  = 1'b1;
				ctrl.zeroExtImm = 1'b1;
				ctrl.aluControl = mipsPkg::aluOr;
			end
			mipsPkg::opLui: begin
				ctrl.regWrite   = 1'b1;
				ctrl.aluSrcImm  = 1'b1;
				ctrl.aluControl = mipsPkg::aluLui;
			end
			mipsPkg::opLw: begin
				ctrl.regWrite   = 1'b1;
				ctrl.memToReg   = 1'b1;
				ctrl.aluSrcImm  = 1'b1;
				ctrl.aluControl = mipsPkg::aluAdd;
			end
			mipsPkg::opSw: begin
				ctrl.memWrite   = 1'b1;
				ctrl.aluSrcImm  = 1'b1;
				ctrl.aluControl = mipsPkg::aluAdd;
			end
			mipsPkg::opBeq: ctrl.branchEq = 1'b1;
			mipsPkg::opBne: ctrl.branchNe = 1'b1;
			mipsPkg::opJ:   ctrl.jump     = 1'b1;
			default:        ctrl = '0;
		endcase
	end

endmodule

// File: logic/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit (
	input  logic [4:0] rsD,
	input  logic [4:0] rtD,
	input  logic       branchD,
	input  logic [4:0] rsE,
	input  logic [4:0] rtE,
	input  logic [4:0] destE,
	input  logic       regWriteE,
	input  logic       memToRegE,
	input  logic [4:0] destM,
	input  logic       regWriteM,
	input  logic       memToRegM,
	input  logic [4:0] destW,
	input  logic       regWriteW,
	input  logic       redirectD,
	output logic       stallF,
	output logic       stallD,
	output logic       flushD,
	output logic       flushE,
	output logic       forwardAD,
	output logic       forwardBD,
	output logic [1:0] forwardAE,
	output logic [1:0] forwardBE
);

	logic usesE;
	logic usesM;
	logic loadStall;
	logic branchStall;

	// decode sources that match a live destination further down
	assign usesE = destE != 5'd0 && (destE == rsD || destE == rtD);
	assign usesM = destM != 5'd0 && (destM == rsD || destM == rtD);

	assign loadStall   = memToRegE && usesE;
	assign branchStall = branchD && ((regWriteE && usesE) || (memToRegM && usesM));

	assign stallF = loadStall || branchStall;
	assign stallD = stallF;
	assign flushE = stallF;
	assign flushD = redirectD && !stallF;

	// decode compare takes the memory-stage ALU result
	assign forwardAD = rsD != 5'd0 && regWriteM && destM == rsD;
	assign forwardBD = rtD != 5'd0 && regWriteM && destM == rtD;

	// memory stage is younger, so it is checked first
	assign forwardAE = (rsE != 5'd0 && regWriteM && destM == rsE) ? mipsPkg::fwdMem :
		(rsE != 5'd0 && regWriteW && destW == rsE) ? mipsPkg::fwdWb : mipsPkg::fwdNone;
	assign forwardBE = (rtE != 5'd0 && regWriteM && destM == rtE) ? mipsPkg::fwdMem :
		(rtE != 5'd0 && regWriteW && destW == rtE) ? mipsPkg::fwdWb : mipsPkg::fwdNone;

endmodule

// File: logic/mipsCore.sv
`timescale 1ns/1ps

module mipsCore #(
	parameter logic [31:0] resetPc = 32'hBFC00000
) (
	input  logic            clk,
	input  logic            arstN,
	output logic [31:0]     pcF,
	input  logic [31:0]     instrF,
	output mipsPkg::dataReq dataOut,
	input  logic [31:0]     readData,
	output mipsPkg::debugWb debugOut
);

	logic [31:0]        instrD;
	mipsPkg::ctrlBundle ctrlD;
	logic [4:0]         rsD, rtD, rsE, rtE, destE, destM, destW;
	logic               branchD, regWriteE, memToRegE, regWriteM, memToRegM, regWriteW;
	logic               redirectD, stallF, stallD, flushD, flushE;
	logic               forwardAD, forwardBD;
	logic [1:0]         forwardAE, forwardBE;
	logic [4:0]         rfRaddrA, rfRaddrB, rfWaddr;
	logic [31:0]        rfRdataA, rfRdataB, rfWdata;
	logic               rfWen;

	datapath #(.resetPc(resetPc)) u_datapath (.*);

	controlDecoder u_controlDecoder (
		.instr(instrD),
		.ctrl(ctrlD)
	);

	hazardUnit u_hazardUnit (.*);

	regFile u_regFile (
		.clk(clk),
		.arstN(arstN),
		.raddrA(rfRaddrA),
		.raddrB(rfRaddrB),
		.rdataA(rfRdataA),
		.rdataB(rfRdataB),
		.wen(rfWen),
		.waddr(rfWaddr),
		.wdata(rfWdata)
	);

endmodule

// File: logic/pipeStage.sv
`timescale 1ns/1ps

module pipeStage #(
	parameter type payloadType = logic [31:0]
) (
	input  logic       clk,
	input  logic       arstN,
	input  logic       enable,
	input  logic       flush,
	input  payloadType d,
	output payloadType q
);

	// an all-zero payload is a bubble
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			q <= '0;
		end else if (flush) begin
			q <= '0;
		end else if (enable) begin
			q <= d;
		end
	end

endmodule

// File: logic/regFile.sv
`timescale 1ns/1ps

module regFile (
	input  logic        clk,
	input  logic        arstN,
	input  logic [4:0]  raddrA,
	input  logic [4:0]  raddrB,
	output logic [31:0] rdataA,
	output logic [31:0] rdataB,
	input  logic        wen,
	input  logic [4:0]  waddr,
	input  logic [31:0] wdata
);

	logic [31:0] regs [32];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && waddr != 5'd0) begin
			regs[waddr] <= wdata;
		end
	end

	// writeback data in the same cycle wins over the stored word
	assign rdataA = (raddrA == 5'd0) ? 32'd0 :
		(wen && waddr == raddrA) ? wdata : regs[raddrA];
	assign rdataB = (raddrB == 5'd0) ? 32'd0 :
		(wen && waddr == raddrB) ? wdata : regs[raddrB];

endmodule

// File: project.f
common/mipsPkg.sv
logic/pipeStage.sv
logic/regFile.sv
logic/controlDecoder.sv
logic/aluUnit.sv
logic/hazardUnit.sv
datapath/datapath.sv
logic/mipsCore.sv
tests/mipsCore_properties.sv
tests/mipsCoreTb.sv

// File: runSim.sh
#!/bin/sh
# build with Verilator, run, and pass only if the pass line shows up
cd "$(dirname "$0")" && \
verilator --binary --timing --assert -f project.f --top-module mipsCoreTb -o simv && \
./obj_dir/simv | tee /dev/stderr | grep -x "RESULT: PASS" > /dev/null && \
echo "simulation passed" || { echo "simulation failed" >&2; exit 1; }

// File: tests/mipsCoreTb.sv
`timescale 1ns/1ps

module mipsCoreTb;

	localparam logic [31:0] resetPc = 32'hBFC00000;
	localparam int clkPeriod = 20;
	localparam int romDepth = 256;
	localparam int ramDepth = 256;

	logic            clk;
	logic            arstN;
	logic [31:0]     pcF;
	logic [31:0]     instrF;
	mipsPkg::dataReq dataOut;
	logic [31:0]     readData;
	mipsPkg::debugWb debugOut;

	logic [31:0] rom [romDepth];
	logic [31:0] ram [ramDepth];
	logic [31:0] romIndex;
	int          romCount;

	// expected records in program order
	logic [31:0] wbPc [$];
	logic [4:0]  wbNum [$];
	logic [31:0] wbData [$];
	logic [31:0] stAddr [$];
	logic [31:0] stData [$];

	int recordCount;
	int wbTotal;
	int stTotal;
	int wbSeen;
	int stSeen;
	int checkCount;
	int errorCount;
	bit loaded;
	bit firstFetchSeen;

	mipsCore #(.resetPc(resetPc)) u_mipsCore (
		.clk(clk),
		.arstN(arstN),
		.pcF(pcF),
		.instrF(instrF),
		.dataOut(dataOut),
		.readData(readData),
		.debugOut(debugOut)
	);

	// fetches past the end of the program read as nop
	always_comb begin
		romIndex = (pcF - resetPc) >> 2;
		instrF = (romIndex < romCount) ? rom[romIndex[7:0]] : 32'h0;
	end

	// data memory answers in the same cycle
	assign readData = ram[dataOut.addr[9:2]];

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		if (expected !== actual) begin
			errorCount++;
			$display("** Error %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic printSummary();
		$display("summary: %0d checks, %0d errors, %0d of %0d writebacks, %0d of %0d stores",
			checkCount, errorCount, wbSeen, wbTotal, stSeen, stTotal);
	endtask

	initial begin
		clk = 1'b0;
		forever begin
			#(clkPeriod / 2) clk = ~clk;
		end
	end

	initial begin : loadTrace
		int fd;
		int code;
		string line;
		byte tag;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] idx;
		fd = $fopen("tests/programTrace.txt", "r");
		if (fd == 0) begin
			$display("cannot open tests/programTrace.txt");
			$display("RESULT: FAIL");
			$finish;
		end else begin
			while (!$feof(fd)) begin
				code = $fgets(line, fd);
				if (code == 0 || line.len() < 2) begin
					continue;
				end
				tag = line.getc(0);
				if (tag == "#") begin
					continue;
				end
				code = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c);
				if (tag == "I") begin
					idx = (a - resetPc) >> 2;
					rom[idx[7:0]] = b;
					if (int'(idx) >= romCount) begin
						romCount = int'(idx) + 1;
					end
					recordCount++;
				end else if (tag == "W") begin
					wbPc.push_back(a);
					wbNum.push_back(b[4:0]);
					wbData.push_back(c);
					recordCount++;
				end else if (tag == "S") begin
					stAddr.push_back(a);
					stData.push_back(b);
					recordCount++;
				end
			end
			$fclose(fd);
			wbTotal = wbPc.size();
			stTotal = stAddr.size();
			loaded = 1'b1;
		end
	end

	initial begin : runTest
		arstN <= 1'b0;
		wait (loaded);
		repeat (10) @(posedge clk);
		arstN <= 1'b1;
		wait (wbSeen >= wbTotal && stSeen >= stTotal);
		// run past the pipeline depth to catch stray writebacks
		repeat (8) @(posedge clk);
		printSummary();
		if (errorCount == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	initial begin : monitor
		for (int i = 0; i < ramDepth; i++) begin
			ram[i] <= 32'hA5000000 | (i << 2);
		end
		forever begin
			@(posedge clk);
			if (arstN && !firstFetchSeen) begin
				checkValue("first fetch pc", resetPc, pcF);
				firstFetchSeen = 1'b1;
			end
			if (debugOut.wen) begin
				if (wbSeen < wbTotal) begin
					checkValue($sformatf("writeback %0d pc", wbSeen), wbPc[wbSeen], debugOut.pc);
					checkValue($sformatf("writeback %0d reg", wbSeen), {27'd0, wbNum[wbSeen]},
						{27'd0, debugOut.wnum});
					checkValue($sformatf("writeback %0d data", wbSeen), wbData[wbSeen],
						debugOut.wdata);
				end else begin
					errorCount++;
					$display("unexpected writeback to r%0d after the last expected one",
						debugOut.wnum);
				end
				wbSeen++;
			end
			if (dataOut.memWrite) begin
				if (stSeen < stTotal) begin
					checkValue($sformatf("store %0d addr", stSeen), stAddr[stSeen], dataOut.addr);
					checkValue($sformatf("store %0d data", stSeen), stData[stSeen],
						dataOut.writeData);
					// every store is a full word
					checkValue($sformatf("store %0d byte enable", stSeen), 32'hF,
						{28'd0, dataOut.byteEnable});
				end else begin
					errorCount++;
					$display("unexpected store to address %h", dataOut.addr);
				end
				stSeen++;
				ram[dataOut.addr[9:2]] <= dataOut.writeData;
			end
		end
	end

	initial begin : watchdog
		wait (loaded);
		#((recordCount * 20 + 100) * clkPeriod);
		errorCount++;
		$display("watchdog expired before all writebacks seen");
		printSummary();
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: tests/mipsCore_properties.sv
`timescale 1ns/1ps

module mipsCore_properties (
	input logic            clk,
	input logic            arstN,
	input logic [31:0]     pcF,
	input mipsPkg::dataReq dataOut,
	input mipsPkg::debugWb debugOut
);

	// r0 destinations retire without a strobe
	wbNotR0: assert property (@(posedge clk) disable iff (!arstN)
		debugOut.wen |-> debugOut.wnum != 5'd0)
		else $error("writeback strobe raised for r0");

	quietInReset: assert property (@(posedge clk)
		!arstN |-> !dataOut.memWrite && !debugOut.wen)
		else $error("store or writeback while reset is asserted");

	pcAligned: assert property (@(posedge clk) disable iff (!arstN)
		pcF[1:0] == 2'b00)
		else $error("fetch address not word aligned");

endmodule

bind mipsCore mipsCore_properties u_properties (
	.clk(clk),
	.arstN(arstN),
	.pcF(pcF),
	.dataOut(dataOut),
	.debugOut(debugOut)
);

// File: tests/programTrace.txt
# columns (hex): I pc word | W pc reg data | S addr data
# data memory word at byte address a starts as A5000000 | a
I BFC00000 3C011234 # lui   r1, 0x1234
I BFC00004 34215678 # ori   r1, r1, 0x5678
I BFC00008 240200F0 # addiu r2, r0, 0xf0
I BFC0000C 00221821 # addu  r3, r1, r2
I BFC00010 00432023 # subu  r4, r2, r3
I BFC00014 00812824 # and   r5, r4, r1
I BFC00018 00A23025 # or    r6, r5, r2
I BFC0001C 0082382A # slt   r7, r4, r2
I BFC00020 0044402A # slt   r8, r2, r4
I BFC00024 00220021 # addu  r0, r1, r2
I BFC00028 00074821 # addu  r9, r0, r7
I BFC0002C 240A0100 # addiu r10, r0, 0x100
I BFC00030 AD410000 # sw    r1, 0(r10)
I BFC00034 AD460004 # sw    r6, 4(r10)
I BFC00038 8D4B0000 # lw    r11, 0(r10)
I BFC0003C 01696021 # addu  r12, r11, r9
I BFC00040 8D4D0008 # lw    r13, 8(r10)
I BFC00044 AD4D000C # sw    r13, 12(r10)
I BFC00048 8D4E000C # lw    r14, 12(r10)
I BFC0004C 11CD0002 # beq   r14, r13, +2 taken
I BFC00050 240F0BAD # addiu r15, r0, 0xbad
I BFC00054 240F0BAE # addiu r15, r0, 0xbae
I BFC00058 240F0011 # addiu r15, r0, 0x11
I BFC0005C 15EF0001 # bne   r15, r15, +1 not taken
I BFC00060 25F00022 # addiu r16, r15, 0x22
I BFC00064 120F0001 # beq   r16, r15, +1 not taken
I BFC00068 16000002 # bne   r16, r0, +2 taken
I BFC0006C 24110BAD # addiu r17, r0, 0xbad
I BFC00070 24110BAE # addiu r17, r0, 0xbae
I BFC00074 0BF00020 # j     0xbfc00080
I BFC00078 24120BAD # addiu r18, r0, 0xbad
I BFC0007C 24120BAE # addiu r18, r0, 0xbae
I BFC00080 26130001 # addiu r19, r16, 1
I BFC00084 AD530010 # sw    r19, 16(r10)
W BFC00000 01 12340000
W BFC00004 01 12345678
W BFC00008 02 000000F0
W BFC0000C 03 12345768
W BFC00010 04 EDCBA988
W BFC00014 05 00000008
W BFC00018 06 000000F8
W BFC0001C 07 00000001
W BFC00020 08 00000000
W BFC00028 09 00000001
W BFC0002C 0A 00000100
W BFC00038 0B 12345678
W BFC0003C 0C 12345679
W BFC00040 0D A5000108
W BFC00048 0E A5000108
W BFC00058 0F 00000011
W BFC00060 10 00000033
W BFC00080 13 00000034
S 00000100 12345678
S 00000104 000000F8
S 0000010C A5000108
S 00000110 00000034
